// File: sensor_dram_pkg.sv
package sensor_dram_pkg;

    // Word and address sizes.
    localparam int DATA_BITS  = 32;
    localparam int ROW_BITS   = 11;
    localparam int COL_BITS   = 10;
    localparam int ADDR_BITS  = ROW_BITS + COL_BITS;
    localparam int WEB_BITS   = 4;

    // Transfer block and capture buffer.
    localparam int BLOCK_WORDS   = 16;
    localparam int INDEX_BITS    = $clog2(BLOCK_WORDS);
    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

    // DRAM timing, counted in NOP cycles.
    localparam int T_RCD     = 2;
    localparam int T_RP      = 2;
    localparam int WAIT_BITS = 2;

    typedef enum logic [1:0] {
        CMD_NOP,
        CMD_ACT,
        CMD_WRITE,
        CMD_PRE
    } dram_cmd_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ACTIVATE,
        WR_RCD_WAIT,
        WR_WRITE,
        WR_PRECHARGE,
        WR_RP_WAIT,
        WR_DONE
    } wr_state_e;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_RUN,
        CAP_DRAIN
    } cap_state_e;

endpackage

// File: sample_if.sv
`timescale 1ns/1ps

// Captured sensor words, tagged with their place in the block.
interface sample_if
    import sensor_dram_pkg::*;
();
    logic                  valid;
    logic [DATA_BITS-1:0]  data;
    logic [INDEX_BITS-1:0] index;
    logic                  last;
    logic                  hold;

    modport src (output valid, data, index, last, input hold);
    modport dst (input valid, data, index, last, output hold);

endinterface

// File: dram_req_if.sv
`timescale 1ns/1ps

// Write requests already split into DRAM row and column.
interface dram_req_if
    import sensor_dram_pkg::*;
();
    logic                 valid;
    logic [ROW_BITS-1:0]  row;
    logic [COL_BITS-1:0]  col;
    logic [DATA_BITS-1:0] data;
    logic                 last;
    logic                 hold;

    modport src (output valid, row, col, data, last, input hold);
    modport dst (input valid, row, col, data, last, output hold);

endinterface

// File: sensor_capture.sv
`timescale 1ns/1ps

module sensor_capture
    import sensor_dram_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  logic                 sensor_ready_i,
    input  logic [DATA_BITS-1:0] sensor_out_i,
    output logic                 sensor_en_o,
    sample_if.src                out
);

    cap_state_e state;
    cap_state_e state_nxt;

    logic [DATA_BITS-1:0]     fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic [FIFO_CNT_BITS-1:0] fifo_cnt;
    logic [INDEX_BITS-1:0]    in_cnt;
    logic [INDEX_BITS-1:0]    out_idx;
    logic                     take;
    logic                     pop;

    // Sensor is only enabled while there is room for another word.
    assign sensor_en_o = (state == CAP_RUN) && (fifo_cnt != FIFO_CNT_BITS'(FIFO_DEPTH));
    assign take        = sensor_en_o && sensor_ready_i;
    assign pop         = out.valid && !out.hold;

    assign out.valid = (fifo_cnt != '0);
    assign out.data  = fifo_mem[rd_ptr];
    assign out.index = out_idx;
    assign out.last  = (out_idx == INDEX_BITS'(BLOCK_WORDS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            CAP_IDLE: begin
                if (start_i) begin
                    state_nxt = CAP_RUN;
                end
            end
            CAP_RUN: begin
                if (take && in_cnt == INDEX_BITS'(BLOCK_WORDS - 1)) begin
                    state_nxt = CAP_DRAIN;
                end
            end
            CAP_DRAIN: begin
                if (pop && out.last) begin
                    state_nxt = CAP_IDLE;
                end
            end
            default: state_nxt = CAP_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= CAP_IDLE;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            in_cnt   <= '0;
            out_idx  <= '0;
        end else begin
            state <= state_nxt;
            if (take) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_cnt <= in_cnt + 1'b1;
            end
            if (pop) begin
                rd_ptr  <= rd_ptr + 1'b1;
                out_idx <= out_idx + 1'b1;
            end
            fifo_cnt <= fifo_cnt + FIFO_CNT_BITS'(take) - FIFO_CNT_BITS'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fifo_mem[wr_ptr] <= sensor_out_i;
        end
    end

    // The pointers on their own must also show room for the word being taken.
    a_no_take_when_full: assert property (
        @(posedge clk) disable iff (rst)
        take |-> (wr_ptr != rd_ptr) || (fifo_cnt == '0)
    );

    // A held word must still be there, unchanged, one cycle later.
    a_hold_steady: assert property (
        @(posedge clk) disable iff (rst)
        out.valid && out.hold |=> out.valid && $stable(out.data) && $stable(out.index)
    );

endmodule

// File: dram_addr_gen.sv
`timescale 1ns/1ps

module dram_addr_gen
    import sensor_dram_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  logic [ADDR_BITS-1:0] base_addr_i,
    sample_if.dst                in,
    dram_req_if.src              out
);

    logic [ADDR_BITS-1:0] base_q;
    logic [ADDR_BITS-1:0] addr_sum;
    logic                 busy_q;
    logic                 accept;

    // Output register blocked means the input must wait too.
    assign in.hold  = out.valid && out.hold;
    assign accept   = in.valid && !in.hold;
    // Sum wraps at the top of the address space.
    assign addr_sum = base_q + ADDR_BITS'(in.index);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q    <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            if (start_i && !busy_q) begin
                busy_q <= 1'b1;
            end else if (accept && in.last) begin
                busy_q <= 1'b0;
            end
            if (accept) begin
                out.valid <= 1'b1;
            end else if (!out.hold) begin
                out.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            base_q <= base_addr_i;
        end
        if (accept) begin
            {out.row, out.col} <= addr_sum;
            out.data           <= in.data;
            out.last           <= in.last;
        end
    end

    // Every sample belongs to a block whose base has been latched.
    a_sample_inside_block: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> busy_q
    );

endmodule

// File: dram_write_ctrl.sv
`timescale 1ns/1ps

module dram_write_ctrl
    import sensor_dram_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    dram_req_if.dst              in,
    output logic                 dram_csn_o,
    output logic                 dram_rasn_o,
    output logic                 dram_casn_o,
    output logic [WEB_BITS-1:0]  dram_wen_o,
    output logic [ROW_BITS-1:0]  dram_a_o,
    output logic [DATA_BITS-1:0] dram_d_o,
    output logic                 done_o
);

    wr_state_e state;
    wr_state_e state_nxt;
    dram_cmd_e cmd;

    logic                 row_open;
    logic [ROW_BITS-1:0]  open_row;
    logic [WAIT_BITS-1:0] wait_cnt;
    logic [COL_BITS-1:0]  col_q;
    logic [DATA_BITS-1:0] data_q;
    logic                 last_q;
    logic                 take;
    logic                 row_hit;
    logic                 rcd_done;
    logic                 rp_done;

    assign row_hit  = row_open && (in.row == open_row);
    assign rcd_done = (wait_cnt == WAIT_BITS'(T_RCD - 1));
    assign rp_done  = (wait_cnt == WAIT_BITS'(T_RP - 1));
    assign in.hold  = !take;
    assign done_o   = (state == WR_DONE);

    always_comb begin
        take      = 1'b0;
        state_nxt = state;
        case (state)
            WR_IDLE, WR_WRITE: begin
                if (state == WR_WRITE && last_q) begin
                    state_nxt = WR_PRECHARGE;
                end else if (!in.valid) begin
                    state_nxt = WR_IDLE;
                end else if (row_hit) begin
                    take      = 1'b1;
                    state_nxt = WR_WRITE;
                end else if (row_open) begin
                    state_nxt = WR_PRECHARGE;
                end else begin
                    state_nxt = WR_ACTIVATE;
                end
            end
            WR_ACTIVATE:  state_nxt = WR_RCD_WAIT;
            WR_RCD_WAIT: begin
                // Take the request in the last NOP so WRITE follows directly.
                if (rcd_done && in.valid) begin
                    take      = 1'b1;
                    state_nxt = WR_WRITE;
                end
            end
            WR_PRECHARGE: state_nxt = WR_RP_WAIT;
            WR_RP_WAIT: begin
                if (rp_done) begin
                    state_nxt = last_q ? WR_DONE : WR_ACTIVATE;
                end
            end
            WR_DONE:      state_nxt = WR_IDLE;
            default:      state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= WR_IDLE;
            row_open <= 1'b0;
            wait_cnt <= '0;
            last_q   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == WR_ACTIVATE) begin
                row_open <= 1'b1;
            end else if (state == WR_PRECHARGE) begin
                row_open <= 1'b0;
            end
            if ((state == WR_RCD_WAIT || state == WR_RP_WAIT) && state_nxt == state) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
            if (take) begin
                last_q <= in.last;
            end else if (state == WR_DONE) begin
                last_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == WR_ACTIVATE) begin
            open_row <= in.row;
        end
        if (take) begin
            col_q  <= in.col;
            data_q <= in.data;
        end
    end

    always_comb begin
        case (state)
            WR_ACTIVATE:  cmd = CMD_ACT;
            WR_WRITE:     cmd = CMD_WRITE;
            WR_PRECHARGE: cmd = CMD_PRE;
            default:      cmd = CMD_NOP;
        endcase
    end

    // Pins idle high for NOP.
    always_comb begin
        dram_csn_o  = 1'b1;
        dram_rasn_o = 1'b1;
        dram_casn_o = 1'b1;
        dram_wen_o  = '1;
        dram_a_o    = '0;
        dram_d_o    = '0;
        case (cmd)
            CMD_ACT: begin
                dram_csn_o  = 1'b0;
                dram_rasn_o = 1'b0;
                dram_a_o    = in.row;
            end
            CMD_WRITE: begin
                dram_csn_o  = 1'b0;
                dram_casn_o = 1'b0;
                dram_wen_o  = '0;
                dram_a_o    = ROW_BITS'(col_q);
                dram_d_o    = data_q;
            end
            CMD_PRE: begin
                dram_csn_o  = 1'b0;
                dram_rasn_o = 1'b0;
                dram_wen_o  = '0;
            end
            default: begin
                dram_csn_o = 1'b1;
            end
        endcase
    end

    a_write_needs_open_row: assert property (
        @(posedge clk) disable iff (rst)
        cmd == CMD_WRITE |-> row_open
    );

    a_act_needs_closed_row: assert property (
        @(posedge clk) disable iff (rst)
        cmd == CMD_ACT |-> !row_open
    );

endmodule

// File: sensor_dram_top.sv
`timescale 1ns/1ps

module sensor_dram_top
    import sensor_dram_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  logic [ADDR_BITS-1:0] base_addr_i,
    input  logic                 sensor_ready_i,
    input  logic [DATA_BITS-1:0] sensor_out_i,
    output logic                 sensor_en_o,
    output logic                 dram_csn_o,
    output logic                 dram_rasn_o,
    output logic                 dram_casn_o,
    output logic [WEB_BITS-1:0]  dram_wen_o,
    output logic [ROW_BITS-1:0]  dram_a_o,
    output logic [DATA_BITS-1:0] dram_d_o,
    output logic                 done_o
);

    sample_if   smp_if ();
    dram_req_if req_if ();

    sensor_capture capture0 (
        .clk            (clk           ),
        .rst            (rst           ),
        .start_i        (start_i       ),
        .sensor_ready_i (sensor_ready_i),
        .sensor_out_i   (sensor_out_i  ),
        .sensor_en_o    (sensor_en_o   ),
        .out            (smp_if.src    )
    );

    dram_addr_gen addr_gen0 (
        .clk         (clk        ),
        .rst         (rst        ),
        .start_i     (start_i    ),
        .base_addr_i (base_addr_i),
        .in          (smp_if.dst ),
        .out         (req_if.src )
    );

    dram_write_ctrl write_ctrl0 (
        .clk         (clk        ),
        .rst         (rst        ),
        .in          (req_if.dst ),
        .dram_csn_o  (dram_csn_o ),
        .dram_rasn_o (dram_rasn_o),
        .dram_casn_o (dram_casn_o),
        .dram_wen_o  (dram_wen_o ),
        .dram_a_o    (dram_a_o   ),
        .dram_d_o    (dram_d_o   ),
        .done_o      (done_o     )
    );

endmodule

// File: tb_sensor_dram.sv
`timescale 1ns/1ps

module tb_sensor_dram
    import sensor_dram_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * BLOCK_WORDS * 40;
    localparam logic [31:0] LFSR_SEED = 32'hd42b_8c92;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Ready density is in eighths and acts counts the rows the block touches.
    typedef struct packed {
        logic [ADDR_BITS-1:0] base;
        int                   density;
        int                   acts;
    } test_t;

    localparam test_t TESTS [NUM_TESTS] = '{
        '{21'h000000, 5, 1},
        '{21'h0003f8, 6, 2},
        '{21'h1ffff8, 4, 2},
        '{21'h000400, 8, 1},
        '{21'h000a05, 2, 1}
    };

    logic                 clk;
    logic                 rst;
    logic                 start_i;
    logic [ADDR_BITS-1:0] base_addr_i;
    logic                 sensor_ready_i;
    logic [DATA_BITS-1:0] sensor_out_i;
    logic                 sensor_en_o;
    logic                 dram_csn_o;
    logic                 dram_rasn_o;
    logic                 dram_casn_o;
    logic [WEB_BITS-1:0]  dram_wen_o;
    logic [ROW_BITS-1:0]  dram_a_o;
    logic [DATA_BITS-1:0] dram_d_o;
    logic                 done_o;

    logic [31:0]          lfsr_q = LFSR_SEED;
    logic [DATA_BITS-1:0] word_q;
    logic [DATA_BITS-1:0] exp_words [$];
    int                   density;
    int                   taken = BLOCK_WORDS;
    logic                 start_seen = 1'b0;

    dram_cmd_e            cmd;
    dram_cmd_e            reset_cmd;
    dram_cmd_e            last_cmd = CMD_NOP;
    logic                 row_open = 1'b0;
    logic [ROW_BITS-1:0]  open_row;
    logic [ADDR_BITS-1:0] cur_base;
    logic [ADDR_BITS-1:0] exp_addr;
    logic [DATA_BITS-1:0] exp_word;
    logic                 block_active = 1'b0;
    int                   nop_cnt = 0;
    int                   gap_need = 0;
    int                   n_writes = 0;
    int                   act_cnt = 0;
    int                   blocks_done = 0;

    sensor_dram_top dut0 (.*);

    // Galois LFSR that steps once for every bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_data(input string name, input logic [DATA_BITS-1:0] got,
                              input logic [DATA_BITS-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_BITS-1:0] got,
                              input logic [ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_cmd(input string name, input dram_cmd_e got, input dram_cmd_e exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s got %h (%s) expected %h (%s)",
                                     name, got, got.name(), exp, exp.name()));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic decode_pins(output dram_cmd_e c);
        c = CMD_NOP;
        if (!dram_csn_o) begin
            if (!dram_rasn_o && dram_casn_o && dram_wen_o == '1) begin
                c = CMD_ACT;
            end else if (dram_rasn_o && !dram_casn_o && dram_wen_o == '0) begin
                c = CMD_WRITE;
            end else if (!dram_rasn_o && dram_casn_o && dram_wen_o == '0) begin
                c = CMD_PRE;
            end else begin
                report_failure($sformatf("DRAM pins show no known command, RASn %b CASn %b WEn %h",
                                         dram_rasn_o, dram_casn_o, dram_wen_o));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        report_failure($sformatf("timeout, no result after %0d cycles", TIMEOUT_CYCLES));
    end

    // Sensor model. A word counts as delivered when enable and ready meet at an edge.
    always @(posedge clk) begin
        if (sensor_en_o && taken >= BLOCK_WORDS) begin
            report_failure("sensor_en_o is high although the block has no words left");
        end
        if (start_seen) begin
            check_bit("sensor_en_o one cycle after start_i", sensor_en_o, 1'b1);
        end
        if (sensor_en_o && sensor_ready_i) begin
            exp_words.push_back(word_q);
            taken++;
            word_q = take_bits(DATA_BITS);
            sensor_out_i <= word_q;
        end
        start_seen = start_i;
        if (start_i) begin
            taken = 0;
        end
        sensor_ready_i <= (take_bits(3) < density);
    end

    // DRAM command monitor.
    always @(posedge clk) begin
        if (!rst) begin
            decode_pins(cmd);
            if (start_i) begin
                block_active = 1'b1;
                cur_base     = TESTS[blocks_done].base;
                n_writes     = 0;
                act_cnt      = 0;
            end
            exp_addr = cur_base + ADDR_BITS'(n_writes);
            if (cmd == CMD_NOP) begin
                nop_cnt++;
            end else begin
                if (nop_cnt < gap_need) begin
                    report_failure($sformatf("only %0d NOP cycles before %s after %s",
                                             nop_cnt, cmd.name(), last_cmd.name()));
                end
                // A pending word whose row is already open must go straight out.
                if (block_active && row_open && n_writes < BLOCK_WORDS &&
                    exp_addr[ADDR_BITS-1:COL_BITS] == open_row) begin
                    check_cmd("command with the needed row open", cmd, CMD_WRITE);
                end
                case (cmd)
                    CMD_ACT: begin
                        if (row_open) begin
                            report_failure("ACT issued while a row is already open");
                        end
                        row_open = 1'b1;
                        open_row = dram_a_o;
                        act_cnt++;
                        gap_need = T_RCD;
                    end
                    CMD_PRE: begin
                        if (!row_open) begin
                            report_failure("PRE issued with no row open");
                        end
                        row_open = 1'b0;
                        gap_need = T_RP;
                    end
                    default: begin
                        if (!row_open) begin
                            report_failure("WRITE issued with no row open");
                        end
                        if (!block_active || n_writes >= BLOCK_WORDS) begin
                            report_failure("WRITE issued outside the words of a block");
                        end
                        if (exp_words.size() == 0) begin
                            report_failure("WRITE issued before the sensor delivered its word");
                        end
                        exp_word = exp_words.pop_front();
                        check_bit("dram_a_o upper bits on WRITE",
                                  |dram_a_o[ROW_BITS-1:COL_BITS], 1'b0);
                        check_addr("write address", {open_row, dram_a_o[COL_BITS-1:0]}, exp_addr);
                        check_data("dram_d_o", dram_d_o, exp_word);
                        n_writes++;
                        gap_need = 0;
                    end
                endcase
                nop_cnt  = 0;
                last_cmd = cmd;
            end
            if (done_o) begin
                if (!block_active) begin
                    report_failure("done_o pulsed with no block in progress");
                end
                check_count("writes in block", n_writes, BLOCK_WORDS);
                check_count("ACT commands in block", act_cnt, TESTS[blocks_done].acts);
                check_cmd("last command before done_o", last_cmd, CMD_PRE);
                if (nop_cnt < T_RP || exp_words.size() != 0) begin
                    report_failure("done_o came too early or with sensor words left over");
                end
                block_active = 1'b0;
                blocks_done++;
            end
        end
    end

    initial begin
        rst            = 1'b1;
        start_i        = 1'b0;
        base_addr_i    = '0;
        sensor_ready_i = 1'b0;
        density        = 0;
        word_q         = take_bits(DATA_BITS);
        sensor_out_i   = word_q;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        decode_pins(reset_cmd);
        check_cmd("command after reset", reset_cmd, CMD_NOP);
        check_bit("dram_csn_o", dram_csn_o, 1'b1);
        check_bit("dram_rasn_o", dram_rasn_o, 1'b1);
        check_bit("dram_casn_o", dram_casn_o, 1'b1);
        check_bit("dram_wen_o all ones", &dram_wen_o, 1'b1);
        check_bit("sensor_en_o", sensor_en_o, 1'b0);
        check_bit("done_o", done_o, 1'b0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            density <= TESTS[t].density;
            @(posedge clk);
            start_i     <= 1'b1;
            base_addr_i <= TESTS[t].base;
            @(posedge clk);
            start_i     <= 1'b0;
            // The base must have been latched with start_i.
            base_addr_i <= ~TESTS[t].base;
            do @(posedge clk); while (!done_o);
            repeat (4) @(posedge clk);
        end

        if (blocks_done != NUM_TESTS) begin
            report_failure("not every block was completed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: sensor_dram.f
sensor_dram_pkg.sv
sample_if.sv
dram_req_if.sv
sensor_capture.sv
dram_addr_gen.sv
dram_write_ctrl.sv
sensor_dram_top.sv
tb_sensor_dram.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sensor_dram \
    -f sensor_dram.f -o sim_sensor_dram > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_sensor_dram > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
